// File: rtl/node_pkg.sv
/*
 * mesh router node shared types
 * coordinates, packet layout and port numbering for a 2D mesh NoC node
 */
`default_nettype none

package node_pkg;

    // ====================
    // mesh constants
    // ====================
    localparam int MESH_DIM  = 8;                  // nodes per mesh side
    localparam int COORD_W   = $clog2(MESH_DIM);   // bits per axis
    localparam int NUM_PORTS = 5;                  // four mesh sides plus local
    localparam int DATA_W    = 8;

    // node position on the mesh
    typedef struct packed {
        logic [COORD_W-1:0] y;
        logic [COORD_W-1:0] x;
    } coord_t;

    // packet as it moves between nodes
    typedef struct packed {
        logic              qos;    // high class wins arbitration first
        logic [1:0]        kind;   // carried through untouched
        coord_t            src;
        coord_t            tgt;
        logic [DATA_W-1:0] data;
    } pkt_t;

    // port numbering
    // the order here is also the fixed arbitration order
    typedef enum logic [2:0] {
        DIR_L = 3'd0,   // local inject / eject
        DIR_N = 3'd1,
        DIR_W = 3'd2,
        DIR_S = 3'd3,
        DIR_E = 3'd4
    } dir_e;

    // one bit per port, indexed by dir_e
    typedef logic [NUM_PORTS-1:0] port_vec_t;

    // one packet per port, indexed by dir_e
    typedef pkt_t [NUM_PORTS-1:0] pkt_vec_t;

endpackage

`default_nettype wire

// File: rtl/xy_route.sv
/*
 * dimension ordered XY route unit
 * x is resolved first, then y, then the packet ejects locally
 */
`timescale 1ns/1ps
`default_nettype none

module xy_route import node_pkg::*; #(
    parameter int unsigned LOCAL_X = 3,
    parameter int unsigned LOCAL_Y = 3
) (
    input  coord_t    tgt_i,
    output port_vec_t req_o
);

    logic x_gt, x_lt;
    logic y_gt, y_lt;

    // own position trimmed to the coordinate width
    localparam logic [COORD_W-1:0] OWN_X = COORD_W'(LOCAL_X);
    localparam logic [COORD_W-1:0] OWN_Y = COORD_W'(LOCAL_Y);

    assign x_gt = tgt_i.x > OWN_X;
    assign x_lt = tgt_i.x < OWN_X;
    assign y_gt = tgt_i.y > OWN_Y;   // north grows with y
    assign y_lt = tgt_i.y < OWN_Y;

    always_comb begin
        req_o = '0;
        if (x_gt) begin
            req_o[DIR_E] = 1'b1;
        end else if (x_lt) begin
            req_o[DIR_W] = 1'b1;
        end else if (y_gt) begin
            req_o[DIR_N] = 1'b1;     // x already matches
        end else if (y_lt) begin
            req_o[DIR_S] = 1'b1;
        end else begin
            req_o[DIR_L] = 1'b1;     // arrived
        end
    end

endmodule

`default_nettype wire

// File: rtl/input_buffer.sv
/*
 * single entry input buffer
 * holds one packet until the switch allocator grants it
 * accepts a new packet in the same cycle the old one leaves
 */
`timescale 1ns/1ps
`default_nettype none

module input_buffer import node_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    input  logic vld_i,
    input  pkt_t pkt_i,
    input  logic release_i,   // entry granted this cycle
    output logic rdy_o,
    output logic vld_o,
    output pkt_t pkt_o
);

    logic vld_q;
    pkt_t pkt_q;
    logic load;

    assign rdy_o = ~vld_q | release_i;   // empty or emptying
    assign load  = vld_i & rdy_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= 1'b0;
        end else if (load) begin
            vld_q <= 1'b1;
        end else if (release_i) begin
            vld_q <= 1'b0;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load) begin
            pkt_q <= pkt_i;
        end
    end

    assign vld_o = vld_q;
    assign pkt_o = pkt_q;

    // allocator must never grant an empty entry
    a_release_needs_entry: assert property (
        @(posedge clk) disable iff (reset_i) release_i |-> vld_o
    ) else $error("input buffer released while empty");

endmodule

`default_nettype wire

// File: rtl/switch_alloc.sv
/*
 * switch allocator
 * one two class fixed priority arbiter per output port
 * qos high requests first, then lowest port index
 */
`timescale 1ns/1ps
`default_nettype none

module switch_alloc import node_pkg::*; (
    input  logic                      clk,
    input  logic                      reset_i,
    input  port_vec_t [NUM_PORTS-1:0] req_i,        // per input
    input  port_vec_t                 vld_i,
    input  port_vec_t                 qos_i,
    input  port_vec_t                 obuf_rdy_i,
    output port_vec_t [NUM_PORTS-1:0] gnt_out_o,    // per output
    output port_vec_t                 gnt_in_o
);

    port_vec_t [NUM_PORTS-1:0] req_out;   // requests regrouped by output
    port_vec_t [NUM_PORTS-1:0] gnt_col;   // grants regrouped by input

    // ====================
    // request transpose
    // ====================
    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                req_out[o][i] = req_i[i][o] & vld_i[i];   // drop stale route bits
            end
        end
    end

    // ====================
    // per output arbiters
    // ====================
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_arb
        port_vec_t hi_req;
        port_vec_t cand;
        port_vec_t first;

        assign hi_req = req_out[o] & qos_i;
        assign cand   = (|hi_req) ? hi_req : req_out[o];   // pick the class
        assign first  = cand & (~cand + port_vec_t'(1));   // lowest set bit

        // nothing leaves unless the output register can take it
        assign gnt_out_o[o] = first & {NUM_PORTS{obuf_rdy_i[o]}};

        a_gnt_onehot: assert property (
            @(posedge clk) disable iff (reset_i) $onehot0(gnt_out_o[o])
        ) else $error("output %0d granted more than one input", o);
    end

    // ====================
    // grants back to inputs
    // ====================
    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            for (int o = 0; o < NUM_PORTS; o++) begin
                gnt_col[i][o] = gnt_out_o[o][i];
            end
        end
    end

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_gnt_in
        assign gnt_in_o[i] = |gnt_col[i];

        // each buffer holds one packet so it can feed one output at most
        a_single_output: assert property (
            @(posedge clk) disable iff (reset_i) $onehot0(gnt_col[i])
        ) else $error("input %0d granted to two outputs", i);
    end

endmodule

`default_nettype wire

// File: rtl/switch_crossbar.sv
/*
 * 5x5 crossbar
 * AND-OR one hot mux per output, driven by the allocator grants
 */
`timescale 1ns/1ps
`default_nettype none

module switch_crossbar import node_pkg::*; (
    input  port_vec_t [NUM_PORTS-1:0] gnt_out_i,   // per output, one hot
    input  pkt_vec_t                  pkt_i,
    output pkt_vec_t                  pkt_o,
    output port_vec_t                 vld_o
);

    always_comb begin
        for (int o = 0; o < NUM_PORTS; o++) begin
            pkt_o[o] = '0;
            for (int i = 0; i < NUM_PORTS; i++) begin
                // masked OR keeps the mux flat
                pkt_o[o] = pkt_o[o] | (pkt_i[i] & {$bits(pkt_t){gnt_out_i[o][i]}});
            end
        end
    end

    // an output carries a packet whenever some input won it
    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_vld
        assign vld_o[o] = |gnt_out_i[o];
    end

endmodule

`default_nettype wire

// File: rtl/output_register.sv
/*
 * single entry output register
 * registered valid/ready slice towards the neighbour node or the core
 */
`timescale 1ns/1ps
`default_nettype none

module output_register import node_pkg::*; (
    input  logic clk,
    input  logic reset_i,
    input  logic vld_i,    // crossbar valid
    input  pkt_t pkt_i,
    input  logic rdy_i,    // from downstream
    output logic rdy_o,    // back to allocator
    output logic vld_o,
    output pkt_t pkt_o
);

    logic vld_q;
    pkt_t pkt_q;
    logic load;

    // can take a packet when empty or when the current one drains
    assign rdy_o = ~vld_q | rdy_i;
    assign load  = vld_i & rdy_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= 1'b0;
        end else if (load) begin
            vld_q <= 1'b1;
        end else if (rdy_i) begin
            vld_q <= 1'b0;   // drained with nothing behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pkt_q <= pkt_i;
        end
    end

    assign vld_o = vld_q;
    assign pkt_o = pkt_q;

    // held packet must not move while the neighbour stalls
    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset_i)
        vld_o && !rdy_i |=> vld_o && $stable(pkt_o)
    ) else $error("output register dropped or changed a stalled packet");

endmodule

`default_nettype wire

// File: rtl/noc_node.sv
/*
 * 2D mesh router node
 * five single entry input buffers, XY route units, QoS switch allocation,
 * crossbar and five registered outputs with valid/ready back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module noc_node import node_pkg::*; #(
    parameter int unsigned LOCAL_X = 3,   // own column
    parameter int unsigned LOCAL_Y = 3    // own row
) (
    input  logic      clk,
    input  logic      reset_i,
    input  port_vec_t in_vld_i,
    input  pkt_vec_t  in_pkt_i,
    input  port_vec_t out_rdy_i,
    output port_vec_t in_rdy_o,
    output port_vec_t out_vld_o,
    output pkt_vec_t  out_pkt_o
);

    port_vec_t                 buf_vld;
    pkt_vec_t                  buf_pkt;
    port_vec_t [NUM_PORTS-1:0] req;        // route request of each input
    port_vec_t                 qos;
    port_vec_t                 obuf_rdy;
    port_vec_t [NUM_PORTS-1:0] gnt_out;    // winning input per output
    port_vec_t                 gnt_in;
    pkt_vec_t                  xbar_pkt;
    port_vec_t                 xbar_vld;

    // ====================
    // input side
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
        input_buffer u_input_buffer (
            .clk       ( clk          ),
            .reset_i   ( reset_i      ),
            .vld_i     ( in_vld_i[p]  ),
            .pkt_i     ( in_pkt_i[p]  ),
            .release_i ( gnt_in[p]    ),
            .rdy_o     ( in_rdy_o[p]  ),
            .vld_o     ( buf_vld[p]   ),
            .pkt_o     ( buf_pkt[p]   )
        );

        xy_route #(
            .LOCAL_X ( LOCAL_X ),
            .LOCAL_Y ( LOCAL_Y )
        ) u_xy_route (
            .tgt_i ( buf_pkt[p].tgt ),
            .req_o ( req[p]         )
        );

        assign qos[p] = buf_pkt[p].qos;
    end

    // ====================
    // allocation and switch
    // ====================
    switch_alloc u_switch_alloc (
        .clk        ( clk      ),
        .reset_i    ( reset_i  ),
        .req_i      ( req      ),
        .vld_i      ( buf_vld  ),
        .qos_i      ( qos      ),
        .obuf_rdy_i ( obuf_rdy ),
        .gnt_out_o  ( gnt_out  ),
        .gnt_in_o   ( gnt_in   )
    );

    switch_crossbar u_switch_crossbar (
        .gnt_out_i ( gnt_out  ),
        .pkt_i     ( buf_pkt  ),
        .pkt_o     ( xbar_pkt ),
        .vld_o     ( xbar_vld )
    );

    // ====================
    // output side
    // ====================
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_out
        output_register u_output_register (
            .clk     ( clk           ),
            .reset_i ( reset_i       ),
            .vld_i   ( xbar_vld[p]   ),
            .pkt_i   ( xbar_pkt[p]   ),
            .rdy_i   ( out_rdy_i[p]  ),
            .rdy_o   ( obuf_rdy[p]   ),
            .vld_o   ( out_vld_o[p]  ),
            .pkt_o   ( out_pkt_o[p]  )
        );
    end

endmodule

`default_nettype wire

// File: test/tb_noc_node.sv
/*
 * directed testbench for the mesh router node
 * routing, local eject, QoS order, back-pressure and parallel traffic
 */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_node import node_pkg::*; ();

    localparam int TIMEOUT = 50;   // cycles allowed per wait
    localparam int OWN_X   = 3;
    localparam int OWN_Y   = 3;

    logic        clk;
    logic        reset_i;
    port_vec_t   in_vld;
    pkt_vec_t    in_pkt;
    port_vec_t   out_rdy;
    port_vec_t   in_rdy;
    port_vec_t   out_vld;
    pkt_vec_t    out_pkt;

    int          errors;
    int          checks;
    logic [31:0] lcg_state;
    pkt_t        rx_q[$];          // packets taken from one output

    noc_node #(
        .LOCAL_X ( OWN_X ),
        .LOCAL_Y ( OWN_Y )
    ) i_dut (
        .clk       ( clk     ),
        .reset_i   ( reset_i ),
        .in_vld_i  ( in_vld  ),
        .in_pkt_i  ( in_pkt  ),
        .out_rdy_i ( out_rdy ),
        .in_rdy_o  ( in_rdy  ),
        .out_vld_o ( out_vld ),
        .out_pkt_o ( out_pkt )
    );

    always #20 clk = ~clk;

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic coord_t coord(int x, int y);
        coord_t c;
        c.x = 3'(x);
        c.y = 3'(y);
        return c;
    endfunction

    // reference XY rule, x first then y
    function automatic int expected_port(coord_t tgt);
        if (tgt.x > OWN_X) return DIR_E;
        if (tgt.x < OWN_X) return DIR_W;
        if (tgt.y > OWN_Y) return DIR_N;
        if (tgt.y < OWN_Y) return DIR_S;
        return DIR_L;
    endfunction

    function automatic pkt_t make_pkt(logic qos, coord_t tgt);
        pkt_t        p;
        logic [31:0] r;
        r        = lcg_next();
        p.qos    = qos;
        p.kind   = r[17:16];
        p.src.x  = r[20:18];
        p.src.y  = r[23:21];
        p.tgt    = tgt;
        p.data   = r[31:24];
        return p;
    endfunction

    // random target that lies in the given direction
    function automatic coord_t target_for(int dir, logic [31:0] r);
        coord_t t;
        t = coord(OWN_X, OWN_Y);
        case (dir)
            DIR_E:   t.x = 3'(4 + r[1:0]);
            DIR_W:   t.x = 3'(r[1:0] % 3);
            DIR_N:   t.y = 3'(4 + r[1:0]);
            DIR_S:   t.y = 3'(r[1:0] % 3);
            default: t = coord(OWN_X, OWN_Y);
        endcase
        if (dir == DIR_E || dir == DIR_W) begin
            t.y = r[4:2];   // any row
        end
        return t;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // drive the masked inputs, return right after the last transfer edge
    task automatic send_pkts(input port_vec_t mask, input pkt_vec_t pkts);
        port_vec_t pending;
        port_vec_t taken;
        int        waited;
        pending = mask;
        waited  = 0;
        @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) begin
                in_vld[p] <= 1'b1;
                in_pkt[p] <= pkts[p];
            end
        end
        while (pending != '0 && waited < TIMEOUT) begin
            @(negedge clk);
            taken   = pending & in_rdy;   // transfer at the coming edge
            pending = pending & ~in_rdy;
            @(posedge clk);
            in_vld <= in_vld & ~taken;
            waited++;
        end
        if (pending != '0) begin
            $display("timeout: input ports %b never accepted their packets", pending);
            errors++;
            in_vld <= in_vld & ~pending;
        end
    endtask

    task automatic wait_out(input int port, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!out_vld[port] && cycles < TIMEOUT);
        if (!out_vld[port]) begin
            $display("timeout: no packet showed up on output port %0d", port);
            errors++;
        end
    endtask

    task automatic collect(input int port, input int count);
        int waited;
        rx_q.delete();
        waited = 0;
        while (rx_q.size() < count && waited < TIMEOUT) begin
            @(negedge clk);
            if (out_vld[port] && out_rdy[port]) begin
                rx_q.push_back(out_pkt[port]);   // handshake at the next edge
            end
            waited++;
        end
        if (rx_q.size() < count) begin
            $display("timeout: output port %0d gave %0d of %0d packets", port, rx_q.size(), count);
            errors++;
        end
    endtask

    task automatic route_one(input string name, input int port, input coord_t tgt);
        pkt_vec_t    pkts;
        int          exp_port;
        int          lat;
        logic [31:0] r;
        r          = lcg_next();
        pkts       = '0;
        pkts[port] = make_pkt(r[31], tgt);
        exp_port   = expected_port(tgt);
        send_pkts(port_vec_t'(1 << port), pkts);
        wait_out(exp_port, lat);
        check_val({name, " latency"}, 32'd2, lat);
        check_val({name, " port"}, 1 << exp_port, out_vld);   // nowhere else
        check_val({name, " packet"}, pkts[port], out_pkt[exp_port]);
    endtask

    // ====================
    // tests
    // ====================
    task automatic test_reset();
        @(negedge clk);
        check_val("reset out_vld", 32'd0, out_vld);
        check_val("reset in_rdy", 32'h1f, in_rdy);
    endtask

    task automatic test_routing();
        coord_t tgts[6];
        tgts[0] = coord(6, 3);   // east, same row
        tgts[1] = coord(0, 3);   // west, same row
        tgts[2] = coord(3, 7);   // north, same column
        tgts[3] = coord(3, 1);   // south, same column
        tgts[4] = coord(5, 0);
        tgts[5] = coord(2, 6);
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int t = 0; t < 6; t++) begin
                route_one($sformatf("routing in%0d tgt%0d", p, t), p, tgts[t]);
            end
        end
    endtask

    task automatic test_local();
        for (int p = 0; p < NUM_PORTS; p++) begin
            route_one($sformatf("local eject in%0d", p), p, coord(OWN_X, OWN_Y));
        end
    endtask

    task automatic test_qos();
        pkt_vec_t pkts;
        int       lat;
        pkts = '0;
        @(posedge clk);
        out_rdy[DIR_E] <= 1'b0;
        pkts[DIR_N] = make_pkt(1'b0, coord(7, 3));
        pkts[DIR_S] = make_pkt(1'b1, coord(5, 1));
        pkts[DIR_L] = make_pkt(1'b0, coord(4, 6));
        send_pkts(port_vec_t'((1 << DIR_N) | (1 << DIR_S) | (1 << DIR_L)), pkts);
        wait_out(DIR_E, lat);   // winner parks in the stalled register
        @(posedge clk);
        out_rdy[DIR_E] <= 1'b1;
        collect(DIR_E, 3);
        if (rx_q.size() == 3) begin
            check_val("qos first south", pkts[DIR_S], rx_q[0]);
            check_val("qos second local", pkts[DIR_L], rx_q[1]);
            check_val("qos third north", pkts[DIR_N], rx_q[2]);
        end
    endtask

    task automatic test_backpressure();
        pkt_vec_t pkts;
        pkt_t     first_pkt;
        pkt_t     second_pkt;
        int       lat;
        @(posedge clk);
        out_rdy[DIR_W] <= 1'b0;
        first_pkt   = make_pkt(1'b0, coord(0, 5));
        second_pkt  = make_pkt(1'b1, coord(1, 2));
        pkts        = '0;
        pkts[DIR_E] = first_pkt;
        send_pkts(port_vec_t'(1 << DIR_E), pkts);
        wait_out(DIR_W, lat);
        for (int c = 0; c < 4; c++) begin
            @(negedge clk);
            check_val("backpressure hold vld", 32'd1, out_vld[DIR_W]);
            check_val("backpressure hold pkt", first_pkt, out_pkt[DIR_W]);
        end
        pkts[DIR_E] = second_pkt;
        send_pkts(port_vec_t'(1 << DIR_E), pkts);
        @(negedge clk);
        check_val("backpressure in_rdy", 32'd0, in_rdy[DIR_E]);   // buffer stuck
        @(posedge clk);
        out_rdy[DIR_W] <= 1'b1;
        collect(DIR_W, 2);
        if (rx_q.size() == 2) begin
            check_val("backpressure first", first_pkt, rx_q[0]);
            check_val("backpressure second", second_pkt, rx_q[1]);
        end
    endtask

    task automatic test_parallel();
        pkt_vec_t    pkts;
        pkt_vec_t    exp_out;
        port_vec_t   seen;
        int          rot;
        int          waited;
        logic [31:0] r;
        for (int round = 0; round < 4; round++) begin
            rot = (lcg_next() >> 16) % NUM_PORTS;
            for (int p = 0; p < NUM_PORTS; p++) begin
                r       = lcg_next();
                pkts[p] = make_pkt(r[31], target_for((p + rot) % NUM_PORTS, r));
                exp_out[expected_port(pkts[p].tgt)] = pkts[p];
            end
            send_pkts('1, pkts);
            seen   = '0;
            waited = 0;
            while (seen != '1 && waited < TIMEOUT) begin
                @(negedge clk);
                for (int o = 0; o < NUM_PORTS; o++) begin
                    if (out_vld[o] && !seen[o]) begin
                        seen[o] = 1'b1;
                        check_val($sformatf("parallel out%0d", o), exp_out[o], out_pkt[o]);
                    end
                end
                waited++;
            end
            if (seen != '1) begin
                $display("timeout: parallel round %0d, outputs seen %b", round, seen);
                errors++;
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        clk       = 1'b0;
        reset_i   = 1'b1;
        in_vld    = '0;
        in_pkt    = '0;
        out_rdy   = '1;
        errors    = 0;
        checks    = 0;
        lcg_state = 32'h095a_6579;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;

        test_reset();
        test_routing();
        test_local();
        test_qos();
        test_backpressure();
        test_parallel();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: noc_node.f
rtl/node_pkg.sv
rtl/xy_route.sv
rtl/input_buffer.sv
rtl/switch_alloc.sv
rtl/switch_crossbar.sv
rtl/output_register.sv
rtl/noc_node.sv
test/tb_noc_node.sv

// File: Bender.yml
package:
  name: noc_node

sources:
  # RTL in compile order
  - rtl/node_pkg.sv
  - rtl/xy_route.sv
  - rtl/input_buffer.sv
  - rtl/switch_alloc.sv
  - rtl/switch_crossbar.sv
  - rtl/output_register.sv
  - rtl/noc_node.sv

  - target: test
    files:
      - test/tb_noc_node.sv
